// File: riscv_cfg.svh
/* core width and reset settings, included by every pipeline control module */
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

// register file index width, 32 registers
`define REG_ADDR_W 5

// data path and pc width
`define XLEN 32

// fetch address right after reset
`define RESET_PC 32'h0000_0000

// sequential fetch step, no compressed instructions
`define INSTR_BYTES 4

`endif

// File: riscv_pkg.sv
/* shared enums for the pipeline control slice
   import with riscv_pkg::* in any module that needs trap kinds or pc select */
`default_nettype none

package riscv_pkg;

    // trap state carried by each instruction through the pipe
    // only MRET changes control flow here
    // ILLEGAL and ECALL are placeholders for the full core
    typedef enum logic [1:0]
    {
        NO_TRAP = 2'd0,
        MRET    = 2'd1,
        ILLEGAL = 2'd2,
        ECALL   = 2'd3
    } exc_t;

    // pc source picked when the fetch pc is redirected
    typedef enum logic
    {
        // branch or jump target from EX
        PC_JUMP = 1'b0,
        // trap return address from the CSR file
        PC_MEPC = 1'b1
    } pc_sel_t;

endpackage : riscv_pkg

`default_nettype wire

// File: controller.sv
/* forwarding, load-use hazard, stall/flush and pc steering for the five-stage pipe
   purely combinational, fed by the registered stage metadata from stage_tracker */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_cfg.svh"

module controller
    import riscv_pkg::*;
(
    // kept so the port shape matches the rest of the core
    input  logic                   clk_i,
    input  logic                   reset_i,

    // sources of the instruction in ID
    input  logic [`REG_ADDR_W-1:0] id_rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] id_rs2_addr_i,

    // ID/EX register
    input  logic [`REG_ADDR_W-1:0] id_ex_rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] id_ex_rs2_addr_i,
    input  logic [`REG_ADDR_W-1:0] id_ex_rd_addr_i,
    input  logic                   id_ex_write_rd_i,
    input  logic                   id_ex_wb_use_mem_i,

    // taken branch or jump resolved in EX
    input  logic                   ex_new_pc_en_i,

    // EX/MEM register
    input  logic [`REG_ADDR_W-1:0] ex_mem_rd_addr_i,
    input  logic                   ex_mem_write_rd_i,
    input  logic                   ex_mem_wb_use_mem_i,
    input  logic [`XLEN-1:0]       ex_mem_alu_result_i,

    // MEM/WB register
    input  logic [`REG_ADDR_W-1:0] mem_wb_rd_addr_i,
    input  logic                   mem_wb_write_rd_i,
    input  logic                   mem_wb_use_mem_i,
    input  logic [`XLEN-1:0]       mem_wb_alu_result_i,
    input  logic [`XLEN-1:0]       mem_wb_dmem_rdata_i,
    input  exc_t                   mem_wb_trap_i,

    input  logic                   instr_valid_i,

    // CSR instructions in ID, EX and MEM
    input  logic                   id_is_csr_i,
    input  logic                   ex_is_csr_i,
    input  logic                   mem_is_csr_i,

    // forwarding into EX
    output logic                   forward_ex_mem_rs1_o,
    output logic                   forward_ex_mem_rs2_o,
    output logic [`XLEN-1:0]       forward_ex_mem_data_o,
    output logic                   forward_mem_wb_rs1_o,
    output logic                   forward_mem_wb_rs2_o,
    output logic [`XLEN-1:0]       forward_mem_wb_data_o,

    // fetch pc steering and CSR side effect
    output logic                   new_pc_en_o,
    output pc_sel_t                pc_sel_o,
    output logic                   csr_mret_o,

    // pipeline register strobes
    output logic                   id_ex_flush_o,
    output logic                   id_ex_stall_o,
    output logic                   if_id_stall_o,
    output logic                   if_id_flush_o,
    output logic                   ex_mem_stall_o,
    output logic                   ex_mem_flush_o
);

    // a stage can forward only if it writes a real register
    // a load in EX/MEM only holds the address, so it is skipped
    logic ex_mem_fwd_ok;
    logic mem_wb_fwd_ok;
    logic load_use_hzrd;
    logic mret_in_wb;

    assign ex_mem_fwd_ok = (ex_mem_rd_addr_i != '0) && ex_mem_write_rd_i && !ex_mem_wb_use_mem_i;
    assign mem_wb_fwd_ok = (mem_wb_rd_addr_i != '0) && mem_wb_write_rd_i;

    // EX/MEM has the newest copy of rd, so it wins over MEM/WB
    always_comb
    begin
        forward_ex_mem_rs1_o = 1'b0;
        forward_ex_mem_rs2_o = 1'b0;
        forward_mem_wb_rs1_o = 1'b0;
        forward_mem_wb_rs2_o = 1'b0;

        if (ex_mem_fwd_ok && (ex_mem_rd_addr_i == id_ex_rs1_addr_i))
            forward_ex_mem_rs1_o = 1'b1;
        else if (mem_wb_fwd_ok && (mem_wb_rd_addr_i == id_ex_rs1_addr_i))
            forward_mem_wb_rs1_o = 1'b1;

        if (ex_mem_fwd_ok && (ex_mem_rd_addr_i == id_ex_rs2_addr_i))
            forward_ex_mem_rs2_o = 1'b1;
        else if (mem_wb_fwd_ok && (mem_wb_rd_addr_i == id_ex_rs2_addr_i))
            forward_mem_wb_rs2_o = 1'b1;
    end

    assign forward_ex_mem_data_o = ex_mem_alu_result_i;
    // loaded value for a load, alu result for anything else
    assign forward_mem_wb_data_o = mem_wb_use_mem_i ? mem_wb_dmem_rdata_i : mem_wb_alu_result_i;

    // load in EX whose rd is read in ID
    // one bubble lets the data reach MEM/WB where it can be forwarded
    assign load_use_hzrd = id_ex_write_rd_i && id_ex_wb_use_mem_i &&
                           ((id_ex_rd_addr_i == id_rs1_addr_i) ||
                            (id_ex_rd_addr_i == id_rs2_addr_i));

    assign mret_in_wb = (mem_wb_trap_i == MRET);

    // branches are predicted not taken
    // a taken one squashes what follows it
    assign id_ex_flush_o  = ex_new_pc_en_i || !instr_valid_i || load_use_hzrd || mret_in_wb;
    assign id_ex_stall_o  = 1'b0;
    assign if_id_stall_o  = load_use_hzrd || ex_is_csr_i || mem_is_csr_i;
    // drain the front end until the CSR write has landed
    assign if_id_flush_o  = id_is_csr_i || ex_is_csr_i || mem_is_csr_i;
    assign ex_mem_stall_o = mret_in_wb;
    assign ex_mem_flush_o = 1'b0;

    // trap return beats a branch from EX
    always_comb
    begin
        new_pc_en_o = 1'b0;
        pc_sel_o    = PC_JUMP;
        csr_mret_o  = 1'b0;

        unique case (mem_wb_trap_i)
            MRET:
            begin
                new_pc_en_o = 1'b1;
                pc_sel_o    = PC_MEPC;
                // tells the CSR file to restore mstatus
                csr_mret_o  = 1'b1;
            end
            // other trap kinds leave the pc to EX
            default:
            begin
                new_pc_en_o = ex_new_pc_en_i;
            end
        endcase
    end

endmodule : controller

`default_nettype wire

// File: stage_tracker.sv
/* control metadata and result registers for ID/EX, EX/MEM and MEM/WB
   applies the flush, stall and bubble strobes from the controller */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_cfg.svh"

module stage_tracker
    import riscv_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,

    // decoded fields of the instruction in ID
    input  logic [`REG_ADDR_W-1:0] id_rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] id_rs2_addr_i,
    input  logic [`REG_ADDR_W-1:0] id_rd_addr_i,
    input  logic                   id_write_rd_i,
    input  logic                   id_use_mem_i,
    input  logic                   id_is_csr_i,
    input  exc_t                   id_trap_i,

    // results from the EX and MEM data path
    input  logic [`XLEN-1:0]       ex_alu_result_i,
    input  logic [`XLEN-1:0]       mem_dmem_rdata_i,

    input  logic                   id_ex_flush_i,
    input  logic                   id_ex_stall_i,
    input  logic                   ex_mem_stall_i,
    input  logic                   ex_mem_flush_i,

    output logic [`REG_ADDR_W-1:0] id_ex_rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] id_ex_rs2_addr_o,
    output logic [`REG_ADDR_W-1:0] id_ex_rd_addr_o,
    output logic                   id_ex_write_rd_o,
    output logic                   id_ex_wb_use_mem_o,
    output logic                   ex_is_csr_o,

    output logic [`REG_ADDR_W-1:0] ex_mem_rd_addr_o,
    output logic                   ex_mem_write_rd_o,
    output logic                   ex_mem_wb_use_mem_o,
    output logic [`XLEN-1:0]       ex_mem_alu_result_o,
    output logic                   mem_is_csr_o,

    output logic [`REG_ADDR_W-1:0] mem_wb_rd_addr_o,
    output logic                   mem_wb_write_rd_o,
    output logic                   mem_wb_use_mem_o,
    output logic [`XLEN-1:0]       mem_wb_alu_result_o,
    output logic [`XLEN-1:0]       mem_wb_dmem_rdata_o,
    output exc_t                   mem_wb_trap_o
);

    exc_t id_ex_trap;
    exc_t ex_mem_trap;

    // ID/EX, flush loads a bubble and beats stall
    always_ff @(posedge clk_i)
    begin
        if (reset_i || id_ex_flush_i)
        begin
            id_ex_rs1_addr_o   <= '0;
            id_ex_rs2_addr_o   <= '0;
            id_ex_rd_addr_o    <= '0;
            id_ex_write_rd_o   <= 1'b0;
            id_ex_wb_use_mem_o <= 1'b0;
            ex_is_csr_o        <= 1'b0;
            id_ex_trap         <= NO_TRAP;
        end
        else if (!id_ex_stall_i)
        begin
            id_ex_rs1_addr_o   <= id_rs1_addr_i;
            id_ex_rs2_addr_o   <= id_rs2_addr_i;
            id_ex_rd_addr_o    <= id_rd_addr_i;
            id_ex_write_rd_o   <= id_write_rd_i;
            id_ex_wb_use_mem_o <= id_use_mem_i;
            ex_is_csr_o        <= id_is_csr_i;
            id_ex_trap         <= id_trap_i;
        end
    end

    // EX/MEM
    always_ff @(posedge clk_i)
    begin
        if (reset_i || ex_mem_flush_i)
        begin
            ex_mem_rd_addr_o    <= '0;
            ex_mem_write_rd_o   <= 1'b0;
            ex_mem_wb_use_mem_o <= 1'b0;
            mem_is_csr_o        <= 1'b0;
            ex_mem_trap         <= NO_TRAP;
        end
        else if (!ex_mem_stall_i)
        begin
            ex_mem_rd_addr_o    <= id_ex_rd_addr_o;
            ex_mem_write_rd_o   <= id_ex_write_rd_o;
            ex_mem_wb_use_mem_o <= id_ex_wb_use_mem_o;
            mem_is_csr_o        <= ex_is_csr_o;
            ex_mem_trap         <= id_ex_trap;
        end
    end

    // MEM/WB never holds
    // a stalled EX/MEM sends a bubble, which retires a pending MRET
    always_ff @(posedge clk_i)
    begin
        if (reset_i || ex_mem_stall_i)
        begin
            mem_wb_rd_addr_o  <= '0;
            mem_wb_write_rd_o <= 1'b0;
            mem_wb_use_mem_o  <= 1'b0;
            mem_wb_trap_o     <= NO_TRAP;
        end
        else
        begin
            mem_wb_rd_addr_o  <= ex_mem_rd_addr_o;
            mem_wb_write_rd_o <= ex_mem_write_rd_o;
            mem_wb_use_mem_o  <= ex_mem_wb_use_mem_o;
            mem_wb_trap_o     <= ex_mem_trap;
        end
    end

    // result words follow the metadata and are ignored in a bubble
    always_ff @(posedge clk_i)
    begin
        if (!ex_mem_stall_i)
            ex_mem_alu_result_o <= ex_alu_result_i;
        mem_wb_alu_result_o <= ex_mem_alu_result_o;
        mem_wb_dmem_rdata_o <= mem_dmem_rdata_i;
    end

endmodule : stage_tracker

`default_nettype wire

// File: pc_gen.sv
/* fetch pc register, steps by one instruction or takes a redirect target */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_cfg.svh"

module pc_gen
    import riscv_pkg::*;
(
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             if_id_stall_i,
    input  logic             new_pc_en_i,
    input  pc_sel_t          pc_sel_i,
    input  logic [`XLEN-1:0] jump_target_i,
    input  logic [`XLEN-1:0] mepc_i,
    output logic [`XLEN-1:0] pc_o
);

    logic [`XLEN-1:0] redirect_pc;

    // trap return or branch target
    always_comb
    begin
        unique case (pc_sel_i)
            PC_MEPC: redirect_pc = mepc_i;
            default: redirect_pc = jump_target_i;
        endcase
    end

    // redirect beats stall, so a mispredict during a hazard is not lost
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
            pc_o <= `RESET_PC;
        else if (new_pc_en_i)
            pc_o <= redirect_pc;
        else if (!if_id_stall_i)
            pc_o <= pc_o + `XLEN'(`INSTR_BYTES);
    end

endmodule : pc_gen

`default_nettype wire

// File: pipe_ctrl_top.sv
/* pipeline control slice top, wiring controller, stage_tracker and pc_gen
   the data path around it is driven from the ports */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_cfg.svh"

module pipe_ctrl_top
    import riscv_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,

    // ID stage fields
    input  logic [`REG_ADDR_W-1:0] id_rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] id_rs2_addr_i,
    input  logic [`REG_ADDR_W-1:0] id_rd_addr_i,
    input  logic                   id_write_rd_i,
    input  logic                   id_use_mem_i,
    input  logic                   id_is_csr_i,
    input  exc_t                   id_trap_i,
    input  logic                   instr_valid_i,

    // EX, MEM and CSR side
    input  logic                   ex_new_pc_en_i,
    input  logic [`XLEN-1:0]       ex_jump_target_i,
    input  logic [`XLEN-1:0]       ex_alu_result_i,
    input  logic [`XLEN-1:0]       mem_dmem_rdata_i,
    input  logic [`XLEN-1:0]       mepc_i,

    output logic [`XLEN-1:0]       pc_o,

    output logic                   forward_ex_mem_rs1_o,
    output logic                   forward_ex_mem_rs2_o,
    output logic [`XLEN-1:0]       forward_ex_mem_data_o,
    output logic                   forward_mem_wb_rs1_o,
    output logic                   forward_mem_wb_rs2_o,
    output logic [`XLEN-1:0]       forward_mem_wb_data_o,

    output logic                   id_ex_flush_o,
    output logic                   id_ex_stall_o,
    output logic                   if_id_stall_o,
    output logic                   if_id_flush_o,
    output logic                   ex_mem_stall_o,
    output logic                   ex_mem_flush_o,
    output logic                   csr_mret_o
);

    // registered stage metadata
    logic [`REG_ADDR_W-1:0] id_ex_rs1_addr;
    logic [`REG_ADDR_W-1:0] id_ex_rs2_addr;
    logic [`REG_ADDR_W-1:0] id_ex_rd_addr;
    logic                   id_ex_write_rd;
    logic                   id_ex_wb_use_mem;
    logic                   ex_is_csr;
    logic [`REG_ADDR_W-1:0] ex_mem_rd_addr;
    logic                   ex_mem_write_rd;
    logic                   ex_mem_wb_use_mem;
    logic [`XLEN-1:0]       ex_mem_alu_result;
    logic                   mem_is_csr;
    logic [`REG_ADDR_W-1:0] mem_wb_rd_addr;
    logic                   mem_wb_write_rd;
    logic                   mem_wb_use_mem;
    logic [`XLEN-1:0]       mem_wb_alu_result;
    logic [`XLEN-1:0]       mem_wb_dmem_rdata;
    exc_t                   mem_wb_trap;

    // pc steering
    logic                   new_pc_en;
    pc_sel_t                pc_sel;

    // ports named like the top ports connect by name
    controller u_controller (
        .id_ex_rs1_addr_i    (id_ex_rs1_addr),
        .id_ex_rs2_addr_i    (id_ex_rs2_addr),
        .id_ex_rd_addr_i     (id_ex_rd_addr),
        .id_ex_write_rd_i    (id_ex_write_rd),
        .id_ex_wb_use_mem_i  (id_ex_wb_use_mem),
        .ex_mem_rd_addr_i    (ex_mem_rd_addr),
        .ex_mem_write_rd_i   (ex_mem_write_rd),
        .ex_mem_wb_use_mem_i (ex_mem_wb_use_mem),
        .ex_mem_alu_result_i (ex_mem_alu_result),
        .mem_wb_rd_addr_i    (mem_wb_rd_addr),
        .mem_wb_write_rd_i   (mem_wb_write_rd),
        .mem_wb_use_mem_i    (mem_wb_use_mem),
        .mem_wb_alu_result_i (mem_wb_alu_result),
        .mem_wb_dmem_rdata_i (mem_wb_dmem_rdata),
        .mem_wb_trap_i       (mem_wb_trap),
        .ex_is_csr_i         (ex_is_csr),
        .mem_is_csr_i        (mem_is_csr),
        .new_pc_en_o         (new_pc_en),
        .pc_sel_o            (pc_sel),
        .*
    );

    stage_tracker u_stage_tracker (
        .id_ex_flush_i       (id_ex_flush_o),
        .id_ex_stall_i       (id_ex_stall_o),
        .ex_mem_stall_i      (ex_mem_stall_o),
        .ex_mem_flush_i      (ex_mem_flush_o),
        .id_ex_rs1_addr_o    (id_ex_rs1_addr),
        .id_ex_rs2_addr_o    (id_ex_rs2_addr),
        .id_ex_rd_addr_o     (id_ex_rd_addr),
        .id_ex_write_rd_o    (id_ex_write_rd),
        .id_ex_wb_use_mem_o  (id_ex_wb_use_mem),
        .ex_is_csr_o         (ex_is_csr),
        .ex_mem_rd_addr_o    (ex_mem_rd_addr),
        .ex_mem_write_rd_o   (ex_mem_write_rd),
        .ex_mem_wb_use_mem_o (ex_mem_wb_use_mem),
        .ex_mem_alu_result_o (ex_mem_alu_result),
        .mem_is_csr_o        (mem_is_csr),
        .mem_wb_rd_addr_o    (mem_wb_rd_addr),
        .mem_wb_write_rd_o   (mem_wb_write_rd),
        .mem_wb_use_mem_o    (mem_wb_use_mem),
        .mem_wb_alu_result_o (mem_wb_alu_result),
        .mem_wb_dmem_rdata_o (mem_wb_dmem_rdata),
        .mem_wb_trap_o       (mem_wb_trap),
        .*
    );

    pc_gen u_pc_gen (
        .if_id_stall_i       (if_id_stall_o),
        .new_pc_en_i         (new_pc_en),
        .pc_sel_i            (pc_sel),
        .jump_target_i       (ex_jump_target_i),
        .*
    );

endmodule : pipe_ctrl_top

`default_nettype wire

// File: tb_pipe_ctrl.sv
/* self-checking testbench for pipe_ctrl_top, acting as the rest of the core
   drives ID, EX, MEM and CSR inputs and checks forwarding, hazards and pc steering */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_cfg.svh"

module tb_pipe_ctrl
    import riscv_pkg::*;
();

    logic                   clk_i;
    logic                   reset_i;
    logic [`REG_ADDR_W-1:0] id_rs1_addr_i;
    logic [`REG_ADDR_W-1:0] id_rs2_addr_i;
    logic [`REG_ADDR_W-1:0] id_rd_addr_i;
    logic                   id_write_rd_i;
    logic                   id_use_mem_i;
    logic                   id_is_csr_i;
    exc_t                   id_trap_i;
    logic                   instr_valid_i;
    logic                   ex_new_pc_en_i;
    logic [`XLEN-1:0]       ex_jump_target_i;
    logic [`XLEN-1:0]       ex_alu_result_i;
    logic [`XLEN-1:0]       mem_dmem_rdata_i;
    logic [`XLEN-1:0]       mepc_i;
    logic [`XLEN-1:0]       pc_o;
    logic                   forward_ex_mem_rs1_o;
    logic                   forward_ex_mem_rs2_o;
    logic [`XLEN-1:0]       forward_ex_mem_data_o;
    logic                   forward_mem_wb_rs1_o;
    logic                   forward_mem_wb_rs2_o;
    logic [`XLEN-1:0]       forward_mem_wb_data_o;
    logic                   id_ex_flush_o;
    logic                   id_ex_stall_o;
    logic                   if_id_stall_o;
    logic                   if_id_flush_o;
    logic                   ex_mem_stall_o;
    logic                   ex_mem_flush_o;
    logic                   csr_mret_o;

    // bookkeeping
    int               errors;
    int               checks;
    int               tests;
    int               test_errs;
    int               i;
    int               waited;
    logic [`XLEN-1:0] rng;
    logic [`XLEN-1:0] alu_now;
    logic [`XLEN-1:0] alu_prev;
    logic [`XLEN-1:0] alu_addr;
    logic [`XLEN-1:0] rdata;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] pc_prev;
    logic [`XLEN-1:0] exp_pc;

    pipe_ctrl_top uut (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // 32-bit xorshift step
    function automatic logic [`XLEN-1:0] xorshift(input logic [`XLEN-1:0] s);
        logic [`XLEN-1:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // outputs are sampled on the falling edge, well away from input changes
    task automatic mid_cycle();
        @(negedge clk_i);
    endtask

    task automatic check(input string name, input logic [`XLEN-1:0] act,
                         input logic [`XLEN-1:0] exp);
        checks++;
        assert (act === exp)
        else
        begin
            $display("mismatch %s: got %h, expected %h", name, act, exp);
            errors++;
        end
    endtask

    task automatic expect_fwd(input logic em1, input logic em2, input logic mw1,
                              input logic mw2);
        check("forward_ex_mem_rs1_o", forward_ex_mem_rs1_o, em1);
        check("forward_ex_mem_rs2_o", forward_ex_mem_rs2_o, em2);
        check("forward_mem_wb_rs1_o", forward_mem_wb_rs1_o, mw1);
        check("forward_mem_wb_rs2_o", forward_mem_wb_rs2_o, mw2);
    endtask

    // one decoded instruction presented in ID
    task automatic issue(input logic [`REG_ADDR_W-1:0] rs1, input logic [`REG_ADDR_W-1:0] rs2,
                         input logic [`REG_ADDR_W-1:0] rd, input logic wr, input logic ld,
                         input logic csr, input exc_t trap);
        id_rs1_addr_i = rs1;
        id_rs2_addr_i = rs2;
        id_rd_addr_i  = rd;
        id_write_rd_i = wr;
        id_use_mem_i  = ld;
        id_is_csr_i   = csr;
        id_trap_i     = trap;
    endtask

    task automatic issue_nop();
        issue('0, '0, '0, 1'b0, 1'b0, 1'b0, NO_TRAP);
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == test_errs)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d errors", tests, name, errors - test_errs);
        test_errs = errors;
    endtask

    // only one source may feed each EX operand
    // no rule ever stalls ID/EX or flushes EX/MEM
    always @(negedge clk_i)
    begin
        if (!reset_i)
        begin
            assert (!(forward_ex_mem_rs1_o && forward_mem_wb_rs1_o))
            else
            begin
                $display("both forward sources selected for rs1");
                errors++;
            end
            assert (!(forward_ex_mem_rs2_o && forward_mem_wb_rs2_o))
            else
            begin
                $display("both forward sources selected for rs2");
                errors++;
            end
            check("id_ex_stall_o", id_ex_stall_o, 1'b0);
            check("ex_mem_flush_o", ex_mem_flush_o, 1'b0);
        end
    end

    initial
    begin
        errors = 0;
        checks = 0;
        tests = 0;
        test_errs = 0;
        rng = 32'd35;
        alu_now = '0;
        reset_i = 1'b1;
        instr_valid_i = 1'b1;
        ex_new_pc_en_i = 1'b0;
        ex_jump_target_i = '0;
        ex_alu_result_i = '0;
        mem_dmem_rdata_i = '0;
        mepc_i = '0;
        issue_nop();
        repeat (3) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        // reset state, then free-running fetch
        mid_cycle();
        check("pc_o", pc_o, `RESET_PC);
        expect_fwd(1'b0, 1'b0, 1'b0, 1'b0);
        check("new_pc_en", uut.new_pc_en, 1'b0);
        check("csr_mret_o", csr_mret_o, 1'b0);
        check("ex_mem_stall_o", ex_mem_stall_o, 1'b0);
        check("if_id_stall_o", if_id_stall_o, 1'b0);
        check("if_id_flush_o", if_id_flush_o, 1'b0);
        check("id_ex_flush_o", id_ex_flush_o, 1'b0);
        exp_pc = `RESET_PC;
        for (i = 0; i < 4; i++)
        begin
            exp_pc = exp_pc + `INSTR_BYTES;
            next_cycle();
            mid_cycle();
            check("pc_o", pc_o, exp_pc);
        end
        // an empty ID slot sends a bubble into ID/EX
        next_cycle();
        instr_valid_i = 1'b0;
        mid_cycle();
        check("id_ex_flush_o", id_ex_flush_o, 1'b1);
        next_cycle();
        instr_valid_i = 1'b1;
        mid_cycle();
        check("id_ex_flush_o", id_ex_flush_o, 1'b0);
        report_test("reset and sequential fetch");

        // three writes to x3, a reader of x3, then writes to x0
        for (i = 0; i < 8; i++)
        begin
            next_cycle();
            case (i)
                0, 1, 2: issue(3, 3, 3, 1'b1, 1'b0, 1'b0, NO_TRAP);
                3:       issue(3, 3, 0, 1'b0, 1'b0, 1'b0, NO_TRAP);
                4, 5:    issue(0, 0, 0, 1'b1, 1'b0, 1'b0, NO_TRAP);
                default: issue_nop();
            endcase
            // the instruction now in ID/EX gets a fresh alu result
            alu_prev = alu_now;
            rng = xorshift(rng);
            alu_now = rng;
            ex_alu_result_i = alu_now;
            mid_cycle();
            if (i >= 2 && i <= 4)
            begin
                expect_fwd(1'b1, 1'b1, 1'b0, 1'b0);
                check("forward_ex_mem_data_o", forward_ex_mem_data_o, alu_prev);
            end
            else if (i >= 5)
                expect_fwd(1'b0, 1'b0, 1'b0, 1'b0);
        end
        report_test("forwarding priority");

        // load to x5, then a reader of x5 on both sources
        next_cycle();
        issue(0, 0, 5, 1'b1, 1'b1, 1'b0, NO_TRAP);
        next_cycle();
        issue(5, 5, 6, 1'b1, 1'b0, 1'b0, NO_TRAP);
        rng = xorshift(rng);
        alu_addr = rng;
        ex_alu_result_i = alu_addr;
        mid_cycle();
        check("if_id_stall_o", if_id_stall_o, 1'b1);
        check("id_ex_flush_o", id_ex_flush_o, 1'b1);
        pc_prev = pc_o;
        // reader held in ID, load data returned from memory
        next_cycle();
        rng = xorshift(rng);
        rdata = ~alu_addr ^ {rng[31:1], 1'b0};
        mem_dmem_rdata_i = rdata;
        mid_cycle();
        check("pc_o", pc_o, pc_prev);
        check("if_id_stall_o", if_id_stall_o, 1'b0);
        next_cycle();
        issue_nop();
        mid_cycle();
        expect_fwd(1'b0, 1'b0, 1'b1, 1'b1);
        check("forward_mem_wb_data_o", forward_mem_wb_data_o, rdata);
        report_test("load-use stall");

        // taken branch resolved in EX
        next_cycle();
        rng = xorshift(rng);
        target = {rng[31:2], 2'b00};
        ex_jump_target_i = target;
        ex_new_pc_en_i = 1'b1;
        mid_cycle();
        check("id_ex_flush_o", id_ex_flush_o, 1'b1);
        check("new_pc_en", uut.new_pc_en, 1'b1);
        next_cycle();
        ex_new_pc_en_i = 1'b0;
        mid_cycle();
        check("pc_o", pc_o, target);
        report_test("mispredict redirect");

        // CSR instruction walking through ID, EX and MEM
        next_cycle();
        issue(0, 0, 0, 1'b0, 1'b0, 1'b1, NO_TRAP);
        mid_cycle();
        check("if_id_flush_o", if_id_flush_o, 1'b1);
        check("if_id_stall_o", if_id_stall_o, 1'b0);
        for (i = 0; i < 3; i++)
        begin
            next_cycle();
            issue_nop();
            mid_cycle();
            check("if_id_stall_o", if_id_stall_o, (i < 2) ? 1'b1 : 1'b0);
        end
        report_test("csr in flight");

        // MRET reaches MEM/WB three cycles after issue
        next_cycle();
        rng = xorshift(rng);
        mepc = {rng[31:2], 2'b00};
        mepc_i = mepc;
        issue(0, 0, 0, 1'b0, 1'b0, 1'b0, MRET);
        waited = 0;
        do
        begin
            next_cycle();
            issue_nop();
            mid_cycle();
            waited++;
        end
        while (!csr_mret_o && waited < 8);
        if (!csr_mret_o)
        begin
            $display("timeout, csr_mret_o never rose after the MRET was issued");
            errors++;
        end
        else
        begin
            check("mret latency", waited, 3);
            check("new_pc_en", uut.new_pc_en, 1'b1);
            check("ex_mem_stall_o", ex_mem_stall_o, 1'b1);
            next_cycle();
            mid_cycle();
            check("csr_mret_o", csr_mret_o, 1'b0);
            check("new_pc_en", uut.new_pc_en, 1'b0);
            check("ex_mem_stall_o", ex_mem_stall_o, 1'b0);
            check("pc_o", pc_o, mepc);
        end
        report_test("mret return");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule : tb_pipe_ctrl

`default_nettype wire

// File: sim.f
+incdir+.
riscv_pkg.sv
controller.sv
stage_tracker.sv
pc_gen.sv
pipe_ctrl_top.sv
tb_pipe_ctrl.sv

// File: Bender.yml
package:
  name: pipe_ctrl

sources:
  - include_dirs:
      - .
    files:
      - riscv_pkg.sv
      - controller.sv
      - stage_tracker.sv
      - pc_gen.sv
      - pipe_ctrl_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pipe_ctrl.sv
